// ==== verilog/rv_exec_pkg.sv ====
package rv_exec_pkg;

	// Instruction class from the decoder
	typedef enum logic [2:0] {
		OP_ARITH,
		OP_BRANCH,
		OP_JUMP,
		OP_LDST,
		OP_MDS,
		OP_SYSTEM
	} op_kind_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
		ALU_OPA, ALU_OPB
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [3:0] {
		MDS_MUL, MDS_MULH, MDS_DIV, MDS_DIVU, MDS_REM, MDS_REMU,
		MDS_SLL, MDS_SRL, MDS_SRA
	} mds_op_e;

	typedef enum logic [3:0] {
		SYS_ECALL, SYS_EBREAK, SYS_ERET
	} sys_op_e;

	// One op field, meaning set by the operation kind
	typedef union packed {
		alu_op_e alu;
		mem_op_e mem;
		mds_op_e mds;
		sys_op_e sys;
	} exec_op_u;

	typedef struct packed {
		op_kind_e    kind;
		exec_op_u    op;
		logic [31:0] op_a;
		logic [31:0] op_b;
		// Branch or jump offset, or store data
		logic [31:0] op_c;
		logic [5:0]  rd;
	} exec_req_t;

	typedef struct packed {
		logic [5:0]  addr;
		logic [31:0] data;
	} rd_write_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstb;
		logic        write;
	} dbus_req_t;

	typedef struct packed {
		logic [31:0] addr;
		mem_op_e     op;
		logic [31:0] wdata;
	} mem_req_t;

	localparam logic [31:0] RESET_PC = 32'h8000_0000;

	// Trap registers share the register write port
	localparam logic [5:0] REG_MEPC = 6'h21;
	localparam logic [5:0] REG_MTVAL = 6'h22;
	localparam logic [5:0] REG_MCAUSE = 6'h23;

	localparam logic [3:0] CAUSE_INSTR_MISALIGN = 4'd0;
	localparam logic [3:0] CAUSE_BREAK = 4'd3;
	localparam logic [3:0] CAUSE_LOAD_MISALIGN = 4'd4;
	localparam logic [3:0] CAUSE_STORE_MISALIGN = 4'd6;
	localparam logic [3:0] CAUSE_ECALL = 4'd11;

endpackage

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
	input  logic [31:0]          a,
	input  logic [31:0]          b,
	input  rv_exec_pkg::alu_op_e op,
	output logic [31:0]          result
);

	logic lt_s;
	logic lt_u;
	logic eq;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = a == b;

	// Compares leave the outcome in bit 0
	always_comb begin
		case (op)
			rv_exec_pkg::ALU_ADD:  result = a + b;
			rv_exec_pkg::ALU_SUB:  result = a - b;
			rv_exec_pkg::ALU_AND:  result = a & b;
			rv_exec_pkg::ALU_OR:   result = a | b;
			rv_exec_pkg::ALU_XOR:  result = a ^ b;
			rv_exec_pkg::ALU_SLT:  result = {31'b0, lt_s};
			rv_exec_pkg::ALU_SLTU: result = {31'b0, lt_u};
			rv_exec_pkg::ALU_EQ:   result = {31'b0, eq};
			rv_exec_pkg::ALU_NE:   result = {31'b0, !eq};
			rv_exec_pkg::ALU_LT:   result = {31'b0, lt_s};
			rv_exec_pkg::ALU_GE:   result = {31'b0, !lt_s};
			rv_exec_pkg::ALU_LTU:  result = {31'b0, lt_u};
			rv_exec_pkg::ALU_GEU:  result = {31'b0, !lt_u};
			rv_exec_pkg::ALU_OPA:  result = a;
			rv_exec_pkg::ALU_OPB:  result = b;
			default:               result = a + b;
		endcase
	end

endmodule

// ==== verilog/rv_mul_div_shift.sv ====
`timescale 1ns/1ps

module rv_mul_div_shift (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  rv_exec_pkg::mds_op_e op,
	input  logic [31:0]          a,
	input  logic [31:0]          b,
	output logic                 done,
	output logic [31:0]          result
);

	logic                 busy;
	logic [5:0]           count;
	rv_exec_pkg::mds_op_e op_q;
	logic                 neg;
	logic [31:0]          hi;
	logic [31:0]          lo;
	logic [31:0]          arg;
	logic [31:0]          abs_a;
	logic [31:0]          abs_b;
	logic                 signed_op;
	logic                 shift_op;
	logic [32:0]          mul_sum;
	logic [33:0]          div_diff;
	logic [63:0]          product;

	assign abs_a = a[31] ? -a : a;
	assign abs_b = b[31] ? -b : b;
	assign signed_op = op inside {rv_exec_pkg::MDS_MULH, rv_exec_pkg::MDS_DIV,
		rv_exec_pkg::MDS_REM};
	assign shift_op = op inside {rv_exec_pkg::MDS_SLL, rv_exec_pkg::MDS_SRL,
		rv_exec_pkg::MDS_SRA};

	// Shift-and-add step, product shifts right through hi:lo
	assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, arg} : 33'd0);
	// Restoring divide trial subtract, bit 33 is the borrow
	assign div_diff = {1'b0, hi, lo[31]} - {2'b00, arg};
	assign product = neg ? -{hi, lo} : {hi, lo};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= 6'd0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= shift_op ? {1'b0, b[4:0]} : 6'd32;
			end else if (busy) begin
				if (count != 6'd0) begin
					count <= count - 6'd1;
				end else begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			op_q <= op;
			hi <= 32'd0;
			lo <= signed_op ? abs_a : a;
			arg <= signed_op ? abs_b : b;
			case (op)
				rv_exec_pkg::MDS_MULH: neg <= a[31] ^ b[31];
				// Divide by zero keeps the all-ones quotient unsigned
				rv_exec_pkg::MDS_DIV:  neg <= (a[31] ^ b[31]) && (b != 32'd0);
				rv_exec_pkg::MDS_REM:  neg <= a[31];
				default:               neg <= 1'b0;
			endcase
		end else if (busy && count != 6'd0) begin
			case (op_q)
				rv_exec_pkg::MDS_MUL, rv_exec_pkg::MDS_MULH: begin
					hi <= mul_sum[32:1];
					lo <= {mul_sum[0], lo[31:1]};
				end
				rv_exec_pkg::MDS_SLL: lo <= {lo[30:0], 1'b0};
				rv_exec_pkg::MDS_SRL: lo <= {1'b0, lo[31:1]};
				rv_exec_pkg::MDS_SRA: lo <= {lo[31], lo[31:1]};
				default: begin
					if (!div_diff[33]) begin
						hi <= div_diff[31:0];
						lo <= {lo[30:0], 1'b1};
					end else begin
						hi <= {hi[30:0], lo[31]};
						lo <= {lo[30:0], 1'b0};
					end
				end
			endcase
		end
	end

	// Quotient in lo, remainder in hi
	always_comb begin
		case (op_q)
			rv_exec_pkg::MDS_MULH: result = product[63:32];
			rv_exec_pkg::MDS_DIV:  result = neg ? -lo : lo;
			rv_exec_pkg::MDS_REM:  result = neg ? -hi : hi;
			rv_exec_pkg::MDS_REMU: result = hi;
			default:               result = lo;
		endcase
	end

endmodule

// ==== verilog/rv_mem_port.sv ====
`timescale 1ns/1ps

module rv_mem_port (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  rv_exec_pkg::mem_req_t  req,
	input  logic                   dready,
	input  logic [31:0]            drdata,
	output logic                   done,
	output logic [31:0]            load_data,
	output logic                   dvalid,
	output rv_exec_pkg::dbus_req_t dbus
);

	logic [3:0]           wstb;
	logic [31:0]          wdata;
	logic                 is_store;
	rv_exec_pkg::mem_op_e op_q;
	logic [7:0]           ld_byte;
	logic [15:0]          ld_half;
	logic [31:0]          ld_ext;

	assign is_store = req.op inside {rv_exec_pkg::MEM_SB, rv_exec_pkg::MEM_SH,
		rv_exec_pkg::MEM_SW};

	// Store data goes out on every lane, strobes pick the live ones
	always_comb begin
		case (req.op)
			rv_exec_pkg::MEM_SB: begin
				wstb = 4'b0001 << req.addr[1:0];
				wdata = {4{req.wdata[7:0]}};
			end
			rv_exec_pkg::MEM_SH: begin
				wstb = req.addr[1] ? 4'b1100 : 4'b0011;
				wdata = {2{req.wdata[15:0]}};
			end
			rv_exec_pkg::MEM_SW: begin
				wstb = 4'b1111;
				wdata = req.wdata;
			end
			default: begin
				wstb = 4'b0000;
				wdata = req.wdata;
			end
		endcase
	end

	always_comb begin
		case (dbus.addr[1:0])
			2'd0:    ld_byte = drdata[7:0];
			2'd1:    ld_byte = drdata[15:8];
			2'd2:    ld_byte = drdata[23:16];
			default: ld_byte = drdata[31:24];
		endcase
		ld_half = dbus.addr[1] ? drdata[31:16] : drdata[15:0];
		case (op_q)
			rv_exec_pkg::MEM_LB:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
			rv_exec_pkg::MEM_LBU: ld_ext = {24'b0, ld_byte};
			rv_exec_pkg::MEM_LH:  ld_ext = {{16{ld_half[15]}}, ld_half};
			rv_exec_pkg::MEM_LHU: ld_ext = {16'b0, ld_half};
			default:              ld_ext = drdata;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			dvalid <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= dvalid && dready;
			if (start) begin
				dvalid <= 1'b1;
			end else if (dready) begin
				dvalid <= 1'b0;
			end
		end
	end

	// Request stays put until the bus accepts it
	always_ff @(posedge clock) begin
		if (start) begin
			dbus <= '{addr: req.addr, wdata: wdata, wstb: wstb, write: is_store};
			op_q <= req.op;
		end
		if (dvalid && dready) begin
			load_data <= ld_ext;
		end
	end

endmodule

// ==== verilog/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   req_valid,
	input  rv_exec_pkg::exec_req_t req,
	input  logic [31:0]            mtvec,
	input  logic                   dready,
	input  logic [31:0]            drdata,
	output logic                   instr_complete,
	output logic                   trap,
	output logic                   tret,
	output logic                   rd_wen,
	output rv_exec_pkg::rd_write_t rd,
	output logic [31:0]            pc,
	output logic                   dvalid,
	output rv_exec_pkg::dbus_req_t dbus
);

	typedef enum logic [3:0] {
		S_EXECUTE,
		S_BRANCH_TAKEN,
		S_JUMP,
		S_MDS_WAIT,
		S_MEM_WAIT,
		S_TRAP_EPC,
		S_TRAP_TVAL,
		S_TRAP_CAUSE,
		S_TRAP_ENTER
	} state_e;

	state_e                state;
	logic                  active;
	logic [31:0]           pc_plus4;
	logic [31:0]           alu_a;
	logic [31:0]           alu_b;
	rv_exec_pkg::alu_op_e  alu_op;
	logic [31:0]           alu_result;
	logic [31:0]           target;
	logic                  ldst_misaligned;
	logic                  is_store;
	logic                  trap_found;
	logic [3:0]            trap_cause;
	logic [31:0]           trap_val;
	logic [31:0]           mtval;
	logic [3:0]            mcause;
	logic                  mds_start;
	logic                  mds_done;
	logic [31:0]           mds_result;
	logic                  mem_go;
	logic                  mem_start;
	rv_exec_pkg::mem_req_t mem_req;
	logic                  mem_done;
	logic [31:0]           load_data;

	// The completing cycle never restarts the held request
	assign active = req_valid && !instr_complete;
	assign pc_plus4 = pc + 32'd4;
	assign target = {alu_result[31:1], 1'b0};
	assign is_store = req.op.mem inside {rv_exec_pkg::MEM_SB, rv_exec_pkg::MEM_SH,
		rv_exec_pkg::MEM_SW};

	// Address add for memory, target add in the two redirect states
	always_comb begin
		alu_a = req.op_a;
		alu_b = req.op_b;
		alu_op = req.op.alu;
		case (state)
			S_BRANCH_TAKEN: begin
				alu_a = pc;
				alu_b = req.op_c;
				alu_op = rv_exec_pkg::ALU_ADD;
			end
			S_JUMP: begin
				alu_b = req.op_c;
				alu_op = rv_exec_pkg::ALU_ADD;
			end
			S_EXECUTE: begin
				if (req.kind == rv_exec_pkg::OP_LDST) begin
					alu_op = rv_exec_pkg::ALU_ADD;
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		case (req.op.mem)
			rv_exec_pkg::MEM_LH, rv_exec_pkg::MEM_LHU, rv_exec_pkg::MEM_SH:
				ldst_misaligned = alu_result[0];
			rv_exec_pkg::MEM_LW, rv_exec_pkg::MEM_SW:
				ldst_misaligned = |alu_result[1:0];
			default:
				ldst_misaligned = 1'b0;
		endcase
	end

	// Exception detection with the cause and mtval it records
	always_comb begin
		trap_found = 1'b0;
		trap_cause = rv_exec_pkg::CAUSE_ECALL;
		trap_val = 32'd0;
		case (state)
			S_EXECUTE: begin
				if (active && req.kind == rv_exec_pkg::OP_LDST && ldst_misaligned) begin
					trap_found = 1'b1;
					trap_cause = is_store ? rv_exec_pkg::CAUSE_STORE_MISALIGN
						: rv_exec_pkg::CAUSE_LOAD_MISALIGN;
					trap_val = alu_result;
				end
				if (active && req.kind == rv_exec_pkg::OP_SYSTEM
					&& req.op.sys inside {rv_exec_pkg::SYS_ECALL, rv_exec_pkg::SYS_EBREAK}) begin
					trap_found = 1'b1;
					if (req.op.sys == rv_exec_pkg::SYS_EBREAK) begin
						trap_cause = rv_exec_pkg::CAUSE_BREAK;
					end
				end
			end
			S_BRANCH_TAKEN, S_JUMP: begin
				// No compressed support, so bit 1 of a target traps
				if (alu_result[1]) begin
					trap_found = 1'b1;
					trap_cause = rv_exec_pkg::CAUSE_INSTR_MISALIGN;
					trap_val = target;
				end
			end
			default: begin
			end
		endcase
	end

	assign mds_start = state == S_EXECUTE && active && req.kind == rv_exec_pkg::OP_MDS;
	assign mem_go = state == S_EXECUTE && active && req.kind == rv_exec_pkg::OP_LDST
		&& !ldst_misaligned;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= S_EXECUTE;
			instr_complete <= 1'b0;
			trap <= 1'b0;
			tret <= 1'b0;
			mem_start <= 1'b0;
			pc <= rv_exec_pkg::RESET_PC;
		end else begin
			instr_complete <= 1'b0;
			trap <= 1'b0;
			tret <= 1'b0;
			mem_start <= mem_go;
			if (trap_found) begin
				state <= S_TRAP_EPC;
			end else begin
				case (state)
					S_EXECUTE: begin
						if (active) begin
							case (req.kind)
								rv_exec_pkg::OP_BRANCH: begin
									if (alu_result[0]) begin
										state <= S_BRANCH_TAKEN;
									end else begin
										pc <= pc_plus4;
										instr_complete <= 1'b1;
									end
								end
								rv_exec_pkg::OP_JUMP: state <= S_JUMP;
								rv_exec_pkg::OP_LDST: state <= S_MEM_WAIT;
								rv_exec_pkg::OP_MDS:  state <= S_MDS_WAIT;
								rv_exec_pkg::OP_SYSTEM: begin
									if (req.op.sys == rv_exec_pkg::SYS_ERET) begin
										pc <= req.op_a;
										tret <= 1'b1;
									end else begin
										pc <= pc_plus4;
									end
									instr_complete <= 1'b1;
								end
								default: begin
									pc <= pc_plus4;
									instr_complete <= 1'b1;
								end
							endcase
						end
					end
					S_BRANCH_TAKEN, S_JUMP: begin
						pc <= target;
						instr_complete <= 1'b1;
						state <= S_EXECUTE;
					end
					S_MDS_WAIT: begin
						if (mds_done) begin
							pc <= pc_plus4;
							instr_complete <= 1'b1;
							state <= S_EXECUTE;
						end
					end
					S_MEM_WAIT: begin
						if (mem_done) begin
							pc <= pc_plus4;
							instr_complete <= 1'b1;
							state <= S_EXECUTE;
						end
					end
					S_TRAP_EPC:   state <= S_TRAP_TVAL;
					S_TRAP_TVAL:  state <= S_TRAP_CAUSE;
					S_TRAP_CAUSE: state <= S_TRAP_ENTER;
					S_TRAP_ENTER: begin
						pc <= mtvec;
						trap <= 1'b1;
						instr_complete <= 1'b1;
						state <= S_EXECUTE;
					end
					default: state <= S_EXECUTE;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (trap_found) begin
			mtval <= trap_val;
			mcause <= trap_cause;
		end
		if (mem_go) begin
			mem_req <= '{addr: alu_result, op: req.op.mem, wdata: req.op_c};
		end
	end

	// Writeback strobe, trap registers go out one per cycle
	always_comb begin
		case (state)
			S_EXECUTE:    rd_wen = active && req.kind == rv_exec_pkg::OP_ARITH;
			S_JUMP:       rd_wen = !alu_result[1];
			S_MDS_WAIT:   rd_wen = mds_done;
			S_MEM_WAIT:   rd_wen = mem_done && !is_store;
			S_TRAP_EPC, S_TRAP_TVAL, S_TRAP_CAUSE: rd_wen = 1'b1;
			default:      rd_wen = 1'b0;
		endcase
		case (state)
			S_TRAP_EPC:   rd.addr = rv_exec_pkg::REG_MEPC;
			S_TRAP_TVAL:  rd.addr = rv_exec_pkg::REG_MTVAL;
			S_TRAP_CAUSE: rd.addr = rv_exec_pkg::REG_MCAUSE;
			default:      rd.addr = req.rd;
		endcase
		case (state)
			S_JUMP:       rd.data = pc_plus4;
			S_MDS_WAIT:   rd.data = mds_result;
			S_MEM_WAIT:   rd.data = load_data;
			S_TRAP_EPC:   rd.data = pc;
			S_TRAP_TVAL:  rd.data = mtval;
			S_TRAP_CAUSE: rd.data = {28'b0, mcause};
			default:      rd.data = alu_result;
		endcase
	end

	rv_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	rv_mul_div_shift u_mds (
		.clock  (clock),
		.reset  (reset),
		.start  (mds_start),
		.op     (req.op.mds),
		.a      (req.op_a),
		.b      (req.op_b),
		.done   (mds_done),
		.result (mds_result)
	);

	rv_mem_port u_mem (
		.clock     (clock),
		.reset     (reset),
		.start     (mem_start),
		.req       (mem_req),
		.dready    (dready),
		.drdata    (drdata),
		.done      (mem_done),
		.load_data (load_data),
		.dvalid    (dvalid),
		.dbus      (dbus)
	);

endmodule

// ==== verilog/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   req_valid,
	input  rv_exec_pkg::exec_req_t req,
	input  logic [31:0]            mtvec,
	input  logic                   dready,
	input  logic [31:0]            drdata,
	output logic                   instr_complete,
	output logic                   trap,
	output logic                   tret,
	output logic                   rd_wen,
	output rv_exec_pkg::rd_write_t rd,
	output logic [31:0]            pc,
	output logic                   dvalid,
	output rv_exec_pkg::dbus_req_t dbus
);

	rv_exec_core u_core (
		.clock          (clock),
		.reset          (reset),
		.req_valid      (req_valid),
		.req            (req),
		.mtvec          (mtvec),
		.dready         (dready),
		.drdata         (drdata),
		.instr_complete (instr_complete),
		.trap           (trap),
		.tret           (tret),
		.rd_wen         (rd_wen),
		.rd             (rd),
		.pc             (pc),
		.dvalid         (dvalid),
		.dbus           (dbus)
	);

endmodule

// ==== bench/rv_exec_tb.sv ====
`timescale 1ns/1ps

module rv_exec_tb;

	localparam logic [31:0] MTVEC = 32'h8000_0100;
	localparam logic [31:0] DATA_BASE = 32'h0000_1000;

	// One instruction with everything the reference model expects of it
	typedef struct packed {
		rv_exec_pkg::exec_req_t       req;
		logic                         bus_exp;
		rv_exec_pkg::dbus_req_t       bus;
		logic [1:0]                   n_wr;
		rv_exec_pkg::rd_write_t [2:0] wr;
		logic [31:0]                  pc_exp;
		logic                         trap_exp;
		logic                         tret_exp;
	} entry_t;

	logic                   clock;
	logic                   reset;
	logic                   req_valid;
	rv_exec_pkg::exec_req_t req;
	logic [31:0]            mtvec;
	logic                   dready = 1'b0;
	logic [31:0]            drdata = 32'd0;
	logic                   instr_complete;
	logic                   trap;
	logic                   tret;
	logic                   rd_wen;
	rv_exec_pkg::rd_write_t rd;
	logic [31:0]            pc;
	logic                   dvalid;
	rv_exec_pkg::dbus_req_t dbus;

	entry_t                 entries [$];
	string                  names [$];
	rv_exec_pkg::rd_write_t writes [$];
	rv_exec_pkg::dbus_req_t bus_seen [$];
	logic [31:0]            data_mem [16];
	logic [31:0]            model_pc;
	integer                 seed = 71285;
	int                     bus_wait = -1;
	int                     errors = 0;
	int                     cycles = 0;
	int                     cycle_limit = 0;

	rv_exec_top dut (
		.clock          (clock),
		.reset          (reset),
		.req_valid      (req_valid),
		.req            (req),
		.mtvec          (mtvec),
		.dready         (dready),
		.drdata         (drdata),
		.instr_complete (instr_complete),
		.trap           (trap),
		.tret           (tret),
		.rd_wen         (rd_wen),
		.rd             (rd),
		.pc             (pc),
		.dvalid         (dvalid),
		.dbus           (dbus)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, an instruction never completed", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Register writes in the order they happen
	always @(posedge clock) begin
		if (!reset && rd_wen) begin
			writes.push_back(rd);
		end
	end

	// Data-bus slave with a random wait of 0 to 3 cycles
	always @(negedge clock) begin
		dready = 1'b0;
		if (!reset && dvalid) begin
			if (bus_wait < 0) begin
				bus_wait = $unsigned($random(seed)) % 4;
			end
			if (bus_wait == 0) begin
				drdata = data_mem[dbus.addr[5:2]];
				dready = 1'b1;
				bus_seen.push_back(dbus);
				bus_wait = -1;
			end else begin
				bus_wait--;
			end
		end
	end

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic compare_ref(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			rv_exec_pkg::ALU_EQ:  return a == b;
			rv_exec_pkg::ALU_NE:  return a != b;
			rv_exec_pkg::ALU_LT:  return $signed(a) < $signed(b);
			rv_exec_pkg::ALU_GE:  return $signed(a) >= $signed(b);
			rv_exec_pkg::ALU_LTU: return a < b;
			rv_exec_pkg::ALU_GEU: return a >= b;
			default:              return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			rv_exec_pkg::ALU_ADD:  return a + b;
			rv_exec_pkg::ALU_SUB:  return a - b;
			rv_exec_pkg::ALU_AND:  return a & b;
			rv_exec_pkg::ALU_OR:   return a | b;
			rv_exec_pkg::ALU_XOR:  return a ^ b;
			rv_exec_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
			rv_exec_pkg::ALU_SLTU: return {31'b0, a < b};
			rv_exec_pkg::ALU_OPA:  return a;
			rv_exec_pkg::ALU_OPB:  return b;
			default:               return {31'b0, compare_ref(op, a, b)};
		endcase
	endfunction

	// RISC-V M-extension results, divide by zero included
	function automatic logic [31:0] mds_ref(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b);
		longint p;
		p = longint'($signed(a)) * longint'($signed(b));
		case (op)
			rv_exec_pkg::MDS_MUL:  return a * b;
			rv_exec_pkg::MDS_MULH: return p[63:32];
			rv_exec_pkg::MDS_DIV:  return (b == 0) ? -32'sd1 : $signed(a) / $signed(b);
			rv_exec_pkg::MDS_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
			rv_exec_pkg::MDS_REM:  return (b == 0) ? $signed(a) : $signed(a) % $signed(b);
			rv_exec_pkg::MDS_REMU: return (b == 0) ? a : a % b;
			rv_exec_pkg::MDS_SLL:  return a << b[4:0];
			rv_exec_pkg::MDS_SRL:  return a >> b[4:0];
			default:               return $signed(a) >>> b[4:0];
		endcase
	endfunction

	function automatic logic [31:0] load_ref(input logic [3:0] op, input logic [31:0] addr);
		logic [31:0] word;
		logic [7:0]  byte_val;
		logic [15:0] half_val;
		word = data_mem[addr[5:2]];
		byte_val = word >> (8 * addr[1:0]);
		half_val = word >> (16 * addr[1]);
		case (op)
			rv_exec_pkg::MEM_LB:  return {{24{byte_val[7]}}, byte_val};
			rv_exec_pkg::MEM_LBU: return {24'b0, byte_val};
			rv_exec_pkg::MEM_LH:  return {{16{half_val[15]}}, half_val};
			rv_exec_pkg::MEM_LHU: return {16'b0, half_val};
			default:              return word;
		endcase
	endfunction

	// Works out the expected outcome and advances the model pc
	task automatic add_entry(input string name, input rv_exec_pkg::op_kind_e kind,
		input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c, input logic [5:0] rd_addr);
		entry_t      e;
		logic [31:0] addr;
		logic [31:0] target;
		logic        taken;
		logic        misaligned;
		logic        trap_now;
		logic [3:0]  cause;
		logic [31:0] tval;
		e = '0;
		e.req.kind = kind;
		e.req.op = op;
		e.req.op_a = a;
		e.req.op_b = b;
		e.req.op_c = c;
		e.req.rd = rd_addr;
		e.pc_exp = model_pc + 32'd4;
		trap_now = 1'b0;
		cause = 4'd0;
		tval = 32'd0;
		addr = a + b;
		case (kind)
			rv_exec_pkg::OP_ARITH: begin
				e.n_wr = 2'd1;
				e.wr[0] = '{addr: rd_addr, data: alu_ref(op, a, b)};
			end
			rv_exec_pkg::OP_BRANCH, rv_exec_pkg::OP_JUMP: begin
				taken = kind == rv_exec_pkg::OP_JUMP || compare_ref(op, a, b);
				target = ((kind == rv_exec_pkg::OP_JUMP ? a : model_pc) + c) & ~32'd1;
				if (taken && target[1]) begin
					trap_now = 1'b1;
					cause = rv_exec_pkg::CAUSE_INSTR_MISALIGN;
					tval = target;
				end else if (taken) begin
					e.pc_exp = target;
					if (kind == rv_exec_pkg::OP_JUMP) begin
						e.n_wr = 2'd1;
						e.wr[0] = '{addr: rd_addr, data: model_pc + 32'd4};
					end
				end
			end
			rv_exec_pkg::OP_LDST: begin
				misaligned = (op inside {rv_exec_pkg::MEM_LH, rv_exec_pkg::MEM_LHU,
					rv_exec_pkg::MEM_SH} && addr[0])
					|| (op inside {rv_exec_pkg::MEM_LW, rv_exec_pkg::MEM_SW} && addr[1:0] != 0);
				if (misaligned) begin
					trap_now = 1'b1;
					tval = addr;
					cause = (op inside {rv_exec_pkg::MEM_SB, rv_exec_pkg::MEM_SH,
						rv_exec_pkg::MEM_SW}) ? rv_exec_pkg::CAUSE_STORE_MISALIGN
						: rv_exec_pkg::CAUSE_LOAD_MISALIGN;
				end else begin
					e.bus_exp = 1'b1;
					e.bus.addr = addr;
					case (op)
						rv_exec_pkg::MEM_SB: begin
							e.bus = '{addr: addr, wdata: {4{c[7:0]}},
								wstb: 4'b0001 << addr[1:0], write: 1'b1};
						end
						rv_exec_pkg::MEM_SH: begin
							e.bus = '{addr: addr, wdata: {2{c[15:0]}},
								wstb: 4'b0011 << (2 * addr[1]), write: 1'b1};
						end
						rv_exec_pkg::MEM_SW: begin
							e.bus = '{addr: addr, wdata: c, wstb: 4'b1111, write: 1'b1};
						end
						default: begin
							e.n_wr = 2'd1;
							e.wr[0] = '{addr: rd_addr, data: load_ref(op, addr)};
						end
					endcase
				end
			end
			rv_exec_pkg::OP_MDS: begin
				e.n_wr = 2'd1;
				e.wr[0] = '{addr: rd_addr, data: mds_ref(op, a, b)};
			end
			default: begin
				if (op == rv_exec_pkg::SYS_ERET) begin
					e.pc_exp = a;
					e.tret_exp = 1'b1;
				end else begin
					trap_now = 1'b1;
					cause = (op == rv_exec_pkg::SYS_EBREAK) ? rv_exec_pkg::CAUSE_BREAK
						: rv_exec_pkg::CAUSE_ECALL;
				end
			end
		endcase
		if (trap_now) begin
			e.n_wr = 2'd3;
			e.wr[0] = '{addr: rv_exec_pkg::REG_MEPC, data: model_pc};
			e.wr[1] = '{addr: rv_exec_pkg::REG_MTVAL, data: tval};
			e.wr[2] = '{addr: rv_exec_pkg::REG_MCAUSE, data: {28'b0, cause}};
			e.pc_exp = MTVEC;
			e.trap_exp = 1'b1;
		end
		model_pc = e.pc_exp;
		entries.push_back(e);
		names.push_back(name);
	endtask

	task automatic check_rd(input rv_exec_pkg::rd_write_t exp, input rv_exec_pkg::rd_write_t act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: rd expected %h:%h, got %h:%h", $time,
				exp.addr, exp.data, act.addr, act.data);
		end
	endtask

	task automatic check_pc(input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: pc expected %h, got %h", $time, exp, act);
		end
	endtask

	task automatic check_dbus(input rv_exec_pkg::dbus_req_t exp, input rv_exec_pkg::dbus_req_t act);
		// Write data means nothing on a read
		if (!exp.write) begin
			act.wdata = exp.wdata;
		end
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: dbus expected %h/%h/%b/%b, got %h/%h/%b/%b", $time,
				exp.addr, exp.wdata, exp.wstb, exp.write,
				act.addr, act.wdata, act.wstb, act.write);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	initial begin
		int     i;
		int     k;
		int     n;
		int     wr_base;
		int     bus_base;
		int     err_before;
		int     passed;
		entry_t e;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mtvec = MTVEC;
		passed = 0;
		model_pc = rv_exec_pkg::RESET_PC;
		for (k = 0; k < 16; k++) begin
			data_mem[k] = fill_word(DATA_BASE + 32'(4 * k));
		end

		add_entry("add", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_ADD, 5, 7, 0, 6'd1);
		add_entry("sub", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_SUB, 3, 10, 0, 6'd2);
		add_entry("and", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_AND, 32'hF0F0_1234,
			32'h0FF0_FF00, 0, 6'd3);
		add_entry("or", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_OR, 32'h1200_0034, 32'h0056_7800,
			0, 6'd4);
		add_entry("xor", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_XOR, 32'hAAAA_5555,
			32'hFFFF_0000, 0, 6'd5);
		add_entry("slt", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_SLT, -5, 2, 0, 6'd6);
		add_entry("sltu", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_SLTU, -5, 2, 0, 6'd7);
		add_entry("pass a", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_OPA, 32'hDEAD_BEEF, 1, 0, 6'd8);
		add_entry("pass b", rv_exec_pkg::OP_ARITH, rv_exec_pkg::ALU_OPB, 1, 32'h0BAD_F00D, 0, 6'd9);
		add_entry("beq taken", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_EQ, 9, 9, 32'h40, 6'd0);
		add_entry("bne not taken", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_NE, 5, 5, 32'h40, 6'd0);
		add_entry("blt back", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_LT, -1, 1, -8, 6'd0);
		add_entry("bgeu not taken", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_GEU, 1, 2, 32'h20, 6'd0);
		add_entry("bge odd offset", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_GE, 7, 7, 32'h11, 6'd0);
		add_entry("bltu misaligned", rv_exec_pkg::OP_BRANCH, rv_exec_pkg::ALU_LTU, 1, 2, 6, 6'd0);
		add_entry("jump", rv_exec_pkg::OP_JUMP, 4'd0, 32'h8000_0200, 0, 8, 6'd10);
		add_entry("jump odd", rv_exec_pkg::OP_JUMP, 4'd0, 32'h8000_0301, 0, 4, 6'd11);
		add_entry("jump misaligned", rv_exec_pkg::OP_JUMP, 4'd0, 32'h8000_0400, 0, 2, 6'd12);
		add_entry("lb", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LB, DATA_BASE, 1, 0, 6'd13);
		add_entry("lbu", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LBU, DATA_BASE, 3, 0, 6'd14);
		add_entry("lh", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LH, DATA_BASE, 2, 0, 6'd15);
		add_entry("lhu", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LHU, DATA_BASE, 6, 0, 6'd16);
		add_entry("lw", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LW, DATA_BASE, 8, 0, 6'd17);
		add_entry("lb high", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LB, DATA_BASE, 32'h13, 0, 6'd18);
		add_entry("sb", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_SB, DATA_BASE, 5, 32'h77A5, 6'd0);
		add_entry("sh", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_SH, DATA_BASE, 32'hA,
			32'h1234_BEEF, 6'd0);
		add_entry("sw", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_SW, DATA_BASE, 32'hC,
			32'hCAFE_F00D, 6'd0);
		add_entry("lhu misaligned", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_LHU, DATA_BASE, 3, 0,
			6'd19);
		add_entry("sw misaligned", rv_exec_pkg::OP_LDST, rv_exec_pkg::MEM_SW, DATA_BASE, 32'h12,
			1, 6'd0);
		add_entry("mul", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_MUL, 12345, 6789, 0, 6'd20);
		add_entry("mul neg", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_MUL, -3, 7, 0, 6'd21);
		add_entry("mulh", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_MULH, 32'h8000_0000,
			32'h7FFF_FFFF, 0, 6'd22);
		add_entry("div", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_DIV, -100, 7, 0, 6'd23);
		add_entry("divu", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_DIVU, 100, 7, 0, 6'd24);
		add_entry("rem", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_REM, -100, 7, 0, 6'd25);
		add_entry("remu", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_REMU, 100, 7, 0, 6'd26);
		add_entry("div by zero", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_DIV, -55, 0, 0, 6'd27);
		add_entry("rem by zero", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_REM, -55, 0, 0, 6'd28);
		add_entry("sll", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_SLL, 32'h1234, 4, 0, 6'd29);
		add_entry("sll zero", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_SLL, 32'h1234, 0, 0, 6'd29);
		add_entry("srl", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_SRL, 32'h8000_0000, 31, 0, 6'd30);
		add_entry("sra", rv_exec_pkg::OP_MDS, rv_exec_pkg::MDS_SRA, 32'h8000_0010, 4, 0, 6'd31);
		add_entry("ecall", rv_exec_pkg::OP_SYSTEM, rv_exec_pkg::SYS_ECALL, 0, 0, 0, 6'd0);
		add_entry("ebreak", rv_exec_pkg::OP_SYSTEM, rv_exec_pkg::SYS_EBREAK, 0, 0, 0, 6'd0);
		add_entry("eret", rv_exec_pkg::OP_SYSTEM, rv_exec_pkg::SYS_ERET, 32'h8000_0040, 0, 0,
			6'd0);
		cycle_limit = 40 * entries.size() + 50;

		repeat (5) @(negedge clock);
		reset = 1'b0;
		check_pc(rv_exec_pkg::RESET_PC, pc);
		check_flag("instr_complete", 1'b0, instr_complete);
		check_flag("trap", 1'b0, trap);
		check_flag("tret", 1'b0, tret);
		check_flag("rd_wen", 1'b0, rd_wen);
		check_flag("dvalid", 1'b0, dvalid);

		for (i = 0; i < entries.size(); i++) begin
			e = entries[i];
			err_before = errors;
			wr_base = writes.size();
			bus_base = bus_seen.size();
			req = e.req;
			req_valid = 1'b1;
			do begin
				@(negedge clock);
			end while (!instr_complete);

			check_flag("trap", e.trap_exp, trap);
			check_flag("tret", e.tret_exp, tret);
			check_pc(e.pc_exp, pc);
			n = writes.size() - wr_base;
			if (n != e.n_wr) begin
				errors++;
				$display("Test %0d: expected %0d register writes but saw %0d", i, e.n_wr, n);
			end
			for (k = 0; k < n && k < e.n_wr; k++) begin
				check_rd(e.wr[k], writes[wr_base + k]);
			end
			n = bus_seen.size() - bus_base;
			if (e.bus_exp && n != 1) begin
				errors++;
				$display("Test %0d: expected one data-bus access but saw %0d", i, n);
			end else if (e.bus_exp) begin
				check_dbus(e.bus, bus_seen[bus_base]);
			end else if (n != 0) begin
				errors++;
				$display("Test %0d: expected no data-bus access but saw %0d", i, n);
			end

			if (errors == err_before) begin
				passed++;
				$display("Test %0d %s: ok", i, names[i]);
			end else begin
				$display("Test %0d %s: failed", i, names[i]);
			end
		end
		req_valid = 1'b0;

		$display("%0d tests, %0d passed, %0d failed, %0d errors", entries.size(), passed,
			entries.size() - passed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/rv_exec_pkg.sv
verilog/rv_alu.sv
verilog/rv_mul_div_shift.sv
verilog/rv_mem_port.sv
verilog/rv_exec_core.sv
verilog/rv_exec_top.sv
bench/rv_exec_tb.sv
